/* flist.f */
src/dl11_pkg.sv
src/dl11_uart_if.sv
src/dl11_baud.sv
src/dl11_uart_tx.sv
src/dl11_uart_rx.sv
src/dl11_regs.sv
src/dl11_top.sv
dv/tb_clock_gen.sv
dv/tb_dl11.sv

/* Makefile */
# Verilator build and run for the DL11 console line unit

VERILATOR ?= verilator
TOP       ?= tb_dl11
RTL_TOP   ?= dl11_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_dl11.sv */
// **************************************
// directed tests for the DL11 line unit
// one serial bit is 64 clk cycles
// outputs sampled on the falling edge
// **************************************

`timescale 1ns/1ps

module tb_dl11
   import dl11_pkg::*;
;

   logic       clk;
   logic       reset;
   addr_t      iopage_addr;
   word_t      data_in;
   logic       iopage_rd;
   logic       iopage_wr;
   logic       iopage_byte_op;
   word_t      data_out;
   logic       decode;
   logic       interrupt;
   logic [7:0] vector;
   logic       rs232_tx;
   logic       rs232_rx;
   int         error_count = 0;
   int         check_count = 0;

   tb_clock_gen tb_clock_gen_inst (
      .clk   (clk),
      .reset (reset)
   );

   dl11_top dl11_top_inst (
      .clk            (clk),
      .reset          (reset),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .data_out       (data_out),
      .decode         (decode),
      .interrupt      (interrupt),
      .vector         (vector),
      .rs232_tx       (rs232_tx),
      .rs232_rx       (rs232_rx)
   );

   task automatic check_word(input string name, input word_t got, input word_t exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic bus_write(input addr_t addr, input word_t data, input logic byte_op);
      @(posedge clk);
      iopage_addr    <= addr;
      data_in        <= data;
      iopage_byte_op <= byte_op;
      iopage_wr      <= 1'b1;
      @(posedge clk);
      iopage_wr      <= 1'b0;
      iopage_byte_op <= 1'b0;
   endtask

   task automatic bus_read(input addr_t addr, input logic byte_op, output word_t data);
      @(posedge clk);
      iopage_addr    <= addr;
      iopage_byte_op <= byte_op;
      iopage_rd      <= 1'b1;
      @(negedge clk);
      data = data_out;
      @(posedge clk);
      iopage_rd      <= 1'b0;
      iopage_byte_op <= 1'b0;
   endtask

   task automatic read_check(input addr_t addr, input logic byte_op, input word_t exp,
                             input string name);
      word_t rd;
      bus_read(addr, byte_op, rd);
      check_word(name, rd, exp);
   endtask

   // poll the flag in bit 7 of a status word until it reaches level
   task automatic poll_status(input addr_t addr, input logic level, input int max_polls,
                              input string what);
      word_t rd;
      int    n;
      n = 0;
      bus_read(addr, 1'b0, rd);
      while (rd[7] !== level && n < max_polls)
      begin
         bus_read(addr, 1'b0, rd);
         n++;
      end
      if (rd[7] !== level)
         report_error({"timeout waiting for ", what});
      else
         check_count++;
   endtask

   task automatic wait_interrupt(input logic level, input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (interrupt !== level && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      if (interrupt !== level)
         report_error({"timeout waiting for ", what});
      else
         check_count++;
   endtask

   task automatic check_decode(input addr_t addr, input logic exp);
      @(posedge clk);
      iopage_addr <= addr;
      @(negedge clk);
      check_word($sformatf("decode at %o", addr), {15'd0, decode}, {15'd0, exp});
   endtask

   // start bit, 8 data bits LSB first, then the given stop level
   task automatic serial_send(input logic [7:0] data, input logic stop);
      logic [9:0] frame;
      frame = {stop, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         rs232_rx <= frame[i];
         repeat (63) @(posedge clk);
      end
      @(posedge clk);
      rs232_rx <= 1'b1;
   endtask

   task automatic serial_expect(input logic [7:0] exp);
      logic [7:0] got;
      int         n;
      n = 0;
      while (rs232_tx && n < 400)
      begin
         @(negedge clk);
         n++;
      end
      if (rs232_tx)
         report_error("no start bit seen on rs232_tx");
      else
      begin
         // move to the middle of the start bit
         repeat (32) @(negedge clk);
         check_word("rs232_tx start bit", {15'd0, rs232_tx}, 16'd0);
         for (int i = 0; i < 8; i++)
         begin
            repeat (64) @(negedge clk);
            got[i] = rs232_tx;
         end
         check_word("rs232_tx data", {8'd0, got}, {8'd0, exp});
         repeat (64) @(negedge clk);
         check_word("rs232_tx stop bit", {15'd0, rs232_tx}, 16'd1);
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (reset && n < 50)
      begin
         @(negedge clk);
         n++;
      end
      if (reset)
         report_error("reset was never released");
   endtask

   task automatic check_reset_state();
      @(negedge clk);
      check_word("interrupt", {15'd0, interrupt}, 16'd0);
      check_word("rs232_tx", {15'd0, rs232_tx}, 16'd1);
      read_check(ADDR_RCSR, 1'b0, 16'h0000, "rcsr");
      read_check(ADDR_RBUF, 1'b0, 16'h0000, "rbuf");
      read_check(ADDR_XCSR, 1'b0, 16'h0080, "xcsr");
      read_check(ADDR_XBUF, 1'b0, 16'h0000, "xbuf");
      check_decode(ADDR_RCSR, 1'b1);
      check_decode(ADDR_RBUF, 1'b1);
      check_decode(ADDR_XCSR, 1'b1);
      check_decode(ADDR_XBUF, 1'b1);
      check_decode(13'o17556, 1'b0);
      check_decode(13'o17570, 1'b0);
      check_decode(13'o00000, 1'b0);
      check_decode(13'o17776, 1'b0);
   endtask

   task automatic transmit_random_byte();
      logic [7:0] tx_byte;
      word_t      tx_word;
      tx_byte = 8'($urandom());
      tx_word = {8'($urandom()), tx_byte};
      bus_write(ADDR_XBUF, tx_word, 1'b0);
      fork
         serial_expect(tx_byte);
         read_check(ADDR_XCSR, 1'b0, 16'h0000, "xcsr after buffer write");
      join
      // the stop bit is still on the line here
      read_check(ADDR_XCSR, 1'b0, 16'h0000, "xcsr during stop bit");
      poll_status(ADDR_XCSR, 1'b1, 100, "transmit ready");
      read_check(ADDR_XBUF, 1'b0, tx_word, "xbuf readback");
   endtask

   task automatic receive_random_byte();
      logic [7:0] rx_byte;
      word_t      rd;
      logic       seen;
      rx_byte = 8'($urandom());
      serial_send(rx_byte, 1'b1);
      poll_status(ADDR_RCSR, 1'b1, 50, "receive done");
      read_check(ADDR_RBUF, 1'b0, {8'd0, rx_byte}, "rbuf");
      read_check(ADDR_RCSR, 1'b0, 16'h0000, "rcsr after buffer read");
      // frame with a low stop bit must be dropped
      serial_send(8'($urandom()), 1'b0);
      seen = 1'b0;
      for (int i = 0; i < 40; i++)
      begin
         bus_read(ADDR_RCSR, 1'b0, rd);
         if (rd[7])
            seen = 1'b1;
      end
      check_word("rcsr done after bad stop bit", {15'd0, seen}, 16'd0);
   endtask

   task automatic interrupt_sequence();
      logic [7:0] rx_byte;
      rx_byte = 8'($urandom());
      serial_send(rx_byte, 1'b1);
      poll_status(ADDR_RCSR, 1'b1, 50, "receive done");
      @(negedge clk);
      check_word("interrupt with enables clear", {15'd0, interrupt}, 16'd0);
      bus_write(ADDR_RCSR, 16'h0040, 1'b0);
      wait_interrupt(1'b1, "receive interrupt");
      check_word("vector receive only", {8'd0, vector}, 16'o060);
      bus_write(ADDR_XCSR, 16'h0040, 1'b0);
      @(negedge clk);
      check_word("vector both pending", {8'd0, vector}, 16'o060);
      bus_write(ADDR_RCSR, 16'h0000, 1'b0);
      @(negedge clk);
      check_word("vector transmit only", {8'd0, vector}, 16'o064);
      @(negedge clk);
      check_word("interrupt transmit only", {15'd0, interrupt}, 16'd1);
      bus_write(ADDR_XCSR, 16'h0000, 1'b0);
      wait_interrupt(1'b0, "interrupt to fall");
      read_check(ADDR_RBUF, 1'b0, {8'd0, rx_byte}, "rbuf after interrupt test");
   endtask

   task automatic byte_lane_access();
      word_t tx_word;
      tx_word = 16'($urandom());
      bus_write(ADDR_XBUF, tx_word, 1'b0);
      read_check(13'o17567, 1'b1, {8'd0, tx_word[15:8]}, "xbuf odd byte");
      read_check(ADDR_XBUF, 1'b1, {8'd0, tx_word[7:0]}, "xbuf even byte");
      poll_status(ADDR_XCSR, 1'b1, 400, "transmit ready after frame");
      // odd byte write takes the high lane, so bit 14 lands on the enable
      bus_write(13'o17565, 16'h4000, 1'b1);
      read_check(ADDR_XCSR, 1'b0, 16'h00c0, "xcsr after odd byte set");
      bus_write(13'o17565, 16'h0040, 1'b1);
      read_check(ADDR_XCSR, 1'b0, 16'h0080, "xcsr after odd byte clear");
   endtask

   initial
   begin
      iopage_addr    = '0;
      data_in        = '0;
      iopage_rd      = 1'b0;
      iopage_wr      = 1'b0;
      iopage_byte_op = 1'b0;
      rs232_rx       = 1'b1;
      void'($urandom(32'h21ae_521d));
      wait_reset_release();
      check_reset_state();
      transmit_random_byte();
      receive_random_byte();
      interrupt_sequence();
      byte_lane_access();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // overall run limit
   initial
   begin
      repeat (60000) @(posedge clk);
      $display("run did not finish within the cycle limit");
      $display("Simulation failed");
      $finish;
   end

endmodule

/* dv/tb_clock_gen.sv */
// **************************************
// testbench clock, 40 ns period
// reset held high for the first 5 rising edges
// **************************************

`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* src/dl11_top.sv */
// **************************************
// DL11 console line unit, single clock domain
// serial side fixed 8N1, rate set by the package constants
// **************************************

`timescale 1ns/1ps

module dl11_top
   import dl11_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  addr_t      iopage_addr,
   input  word_t      data_in,
   input  logic       iopage_rd,
   input  logic       iopage_wr,
   input  logic       iopage_byte_op,
   output word_t      data_out,
   output logic       decode,
   output logic       interrupt,
   output logic [7:0] vector,
   output logic       rs232_tx,
   input  logic       rs232_rx
);

   logic tick;

   dl11_uart_if uart_if ();

   dl11_baud dl11_baud_inst (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   dl11_uart_tx dl11_uart_tx_inst (
      .clk      (clk),
      .reset    (reset),
      .tick     (tick),
      .uif      (uart_if.tx),
      .rs232_tx (rs232_tx)
   );

   dl11_uart_rx dl11_uart_rx_inst (
      .clk      (clk),
      .reset    (reset),
      .tick     (tick),
      .rs232_rx (rs232_rx),
      .uif      (uart_if.rx)
   );

   dl11_regs dl11_regs_inst (
      .clk            (clk),
      .reset          (reset),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .data_out       (data_out),
      .decode         (decode),
      .interrupt      (interrupt),
      .vector         (vector),
      .uif            (uart_if.regs)
   );

endmodule

/* src/dl11_regs.sv */
// **************************************
// DL11 register block, four words at 17560..17566
// decode ignores address bit 0, odd byte lane rule applies
// one interrupt request line, receive vector wins
// **************************************

`timescale 1ns/1ps

module dl11_regs
   import dl11_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  addr_t       iopage_addr,
   input  word_t       data_in,
   input  logic        iopage_rd,
   input  logic        iopage_wr,
   input  logic        iopage_byte_op,
   output word_t       data_out,
   output logic        decode,
   output logic        interrupt,
   output logic [7:0]  vector,
   dl11_uart_if.regs   uif
);

   logic       sel_rcsr;
   logic       sel_rbuf;
   logic       sel_xcsr;
   logic       sel_xbuf;
   word_t      reg_out;
   word_t      reg_in;
   word_t      tto_data;
   logic       rx_ie;
   logic       tx_ie;
   logic       tto_ready;
   logic       tti_full;
   logic       tto_data_wr;
   logic       tti_data_rd;
   logic       rx_int;
   logic       tx_int;
   tto_state_e tto_state;
   tti_state_e tti_state;

   // word decode
   assign sel_rcsr = iopage_addr[12:1] == ADDR_RCSR[12:1];
   assign sel_rbuf = iopage_addr[12:1] == ADDR_RBUF[12:1];
   assign sel_xcsr = iopage_addr[12:1] == ADDR_XCSR[12:1];
   assign sel_xbuf = iopage_addr[12:1] == ADDR_XBUF[12:1];
   assign decode   = sel_rcsr || sel_rbuf || sel_xcsr || sel_xbuf;

   always_comb
   begin
      reg_out = '0;
      if (iopage_rd)
      begin
         if (sel_rcsr)
         begin
            reg_out[CSR_RDY_BIT] = tti_full;
            reg_out[CSR_IE_BIT]  = rx_ie;
         end
         else if (sel_rbuf)
            reg_out = {8'h00, uif.rx_data};
         else if (sel_xcsr)
         begin
            reg_out[CSR_RDY_BIT] = tto_ready;
            reg_out[CSR_IE_BIT]  = tx_ie;
         end
         else if (sel_xbuf)
            reg_out = tto_data;
      end
   end

   // odd byte read returns the high byte in the low lane
   assign data_out = iopage_byte_op ?
                     {8'h00, iopage_addr[0] ? reg_out[15:8] : reg_out[7:0]} : reg_out;

   // odd byte write takes its data from the high lane
   assign reg_in = (iopage_byte_op && iopage_addr[0]) ? {8'h00, data_in[15:8]} : data_in;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tto_data <= '0;
         rx_ie    <= 1'b0;
         tx_ie    <= 1'b0;
      end
      else if (iopage_wr)
      begin
         if (sel_rcsr)
            rx_ie <= reg_in[CSR_IE_BIT];
         if (sel_xcsr)
            tx_ie <= reg_in[CSR_IE_BIT];
         if (sel_xbuf)
            tto_data <= reg_in;
      end
   end

   assign tto_data_wr = iopage_wr && sel_xbuf;
   assign tti_data_rd = iopage_rd && sel_rbuf;

   // tto: hand the character over, then hold ready low until the frame is out
   always_ff @(posedge clk)
   begin
      if (reset)
         tto_state <= TTO_IDLE;
      else
         case (tto_state)
            TTO_IDLE:         if (tto_data_wr) tto_state <= TTO_WAIT_ACK;
            TTO_WAIT_ACK:     if (uif.ld_tx_ack) tto_state <= TTO_WAIT_ACK_LOW;
            TTO_WAIT_ACK_LOW: if (!uif.ld_tx_ack) tto_state <= TTO_WAIT_EMPTY;
            TTO_WAIT_EMPTY:   if (uif.tx_empty) tto_state <= TTO_IDLE;
            default:          tto_state <= TTO_IDLE;
         endcase
   end

   // tti: pull the character out of the UART, then wait for the host read
   always_ff @(posedge clk)
   begin
      if (reset)
         tti_state <= TTI_IDLE;
      else
         case (tti_state)
            TTI_IDLE:         if (!uif.rx_empty) tti_state <= TTI_WAIT_ACK;
            TTI_WAIT_ACK:     if (uif.uld_rx_ack) tti_state <= TTI_WAIT_ACK_LOW;
            TTI_WAIT_ACK_LOW: if (!uif.uld_rx_ack) tti_state <= TTI_FULL;
            TTI_FULL:         if (tti_data_rd) tti_state <= TTI_IDLE;
            default:          tti_state <= TTI_IDLE;
         endcase
   end

   assign uif.ld_tx_req  = tto_state == TTO_WAIT_ACK;
   assign uif.tx_data    = tto_data[7:0];
   assign uif.uld_rx_req = tti_state == TTI_WAIT_ACK;
   assign tto_ready      = tto_state == TTO_IDLE;
   assign tti_full       = tti_state == TTI_FULL;

   assign rx_int = rx_ie && tti_full;
   assign tx_int = tx_ie && tto_ready;
   assign vector = rx_int ? VEC_RX : (tx_int ? VEC_TX : 8'h00);

   always_ff @(posedge clk)
   begin
      if (reset)
         interrupt <= 1'b0;
      else
         interrupt <= rx_int || tx_int;
   end

   // a request raised from idle is answered by the UART half in the next cycle
   a_tx_req_ack : assert property (@(posedge clk) disable iff (reset)
                                   $rose(uif.ld_tx_req) |=> uif.ld_tx_ack);
   a_rx_req_ack : assert property (@(posedge clk) disable iff (reset)
                                   $rose(uif.uld_rx_req) |=> uif.uld_rx_ack);

endmodule

/* src/dl11_uart_rx.sv */
// **************************************
// 8N1 receiver with one character holding register
// a new frame overwrites an unread character, overrun is silent
// frames with a low stop bit are dropped
// **************************************

`timescale 1ns/1ps

module dl11_uart_rx
   import dl11_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   tick,
   input  logic   rs232_rx,
   dl11_uart_if.rx uif
);

   rx_state_e       state;
   logic [OS_W-1:0] os_cnt;
   logic [2:0]      bit_cnt;
   logic [7:0]      shreg;
   logic            rx_s1;
   logic            rx_s2;
   logic            rx_prev;
   logic            fall;

   // two flop synchronizer plus one stage for edge detect
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_s1   <= 1'b1;
         rx_s2   <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_s1   <= rs232_rx;
         rx_s2   <= rx_s1;
         rx_prev <= rx_s2;
      end
   end

   assign fall = rx_prev && !rx_s2;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state          <= RX_IDLE;
         os_cnt         <= '0;
         bit_cnt        <= '0;
         uif.uld_rx_ack <= 1'b0;
         uif.rx_empty   <= 1'b1;
         uif.rx_data    <= '0;
      end
      else
      begin
         // unload handshake empties the holding register
         if (uif.uld_rx_req && !uif.uld_rx_ack)
         begin
            uif.uld_rx_ack <= 1'b1;
            uif.rx_empty   <= 1'b1;
         end
         else if (!uif.uld_rx_req)
            uif.uld_rx_ack <= 1'b0;

         case (state)
            RX_IDLE:
               if (fall)
               begin
                  state  <= RX_START;
                  os_cnt <= '0;
               end
            RX_START:
               if (tick)
               begin
                  if (os_cnt == OS_HALF)
                  begin
                     // line still low at mid start bit
                     state   <= rx_s2 ? RX_IDLE : RX_DATA;
                     os_cnt  <= '0;
                     bit_cnt <= '0;
                  end
                  else
                     os_cnt <= os_cnt + OS_W'(1);
               end
            RX_DATA:
               if (tick)
               begin
                  if (os_cnt == OS_LAST)
                  begin
                     os_cnt  <= '0;
                     shreg   <= {rx_s2, shreg[7:1]};
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7)
                        state <= RX_STOP;
                  end
                  else
                     os_cnt <= os_cnt + OS_W'(1);
               end
            RX_STOP:
               if (tick)
               begin
                  if (os_cnt == OS_LAST)
                  begin
                     state <= RX_IDLE;
                     if (rx_s2)
                     begin
                        uif.rx_data  <= shreg;
                        uif.rx_empty <= 1'b0;
                     end
                  end
                  else
                     os_cnt <= os_cnt + OS_W'(1);
               end
            default:
               state <= RX_IDLE;
         endcase
      end
   end

endmodule

/* src/dl11_uart_tx.sv */
// **************************************
// 8N1 transmitter, LSB first, no parity
// a load is only taken while the line is idle and empty
// **************************************

`timescale 1ns/1ps

module dl11_uart_tx
   import dl11_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   tick,
   dl11_uart_if.tx uif,
   output logic   rs232_tx
);

   tx_state_e       state;
   logic [OS_W-1:0] os_cnt;
   logic [2:0]      bit_cnt;
   logic [7:0]      shreg;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= TX_IDLE;
         os_cnt        <= '0;
         bit_cnt       <= '0;
         rs232_tx      <= 1'b1;
         uif.ld_tx_ack <= 1'b0;
         uif.tx_empty  <= 1'b1;
      end
      else
      begin
         // load handshake
         if (uif.ld_tx_req && !uif.ld_tx_ack && uif.tx_empty)
         begin
            shreg         <= uif.tx_data;
            uif.ld_tx_ack <= 1'b1;
            uif.tx_empty  <= 1'b0;
         end
         else if (!uif.ld_tx_req)
            uif.ld_tx_ack <= 1'b0;

         if (tick)
         begin
            case (state)
               TX_IDLE:
                  if (!uif.tx_empty)
                  begin
                     state    <= TX_START;
                     os_cnt   <= '0;
                     rs232_tx <= 1'b0;
                  end
               TX_START:
                  if (os_cnt == OS_LAST)
                  begin
                     state    <= TX_DATA;
                     os_cnt   <= '0;
                     bit_cnt  <= '0;
                     rs232_tx <= shreg[0];
                  end
                  else
                     os_cnt <= os_cnt + OS_W'(1);
               TX_DATA:
                  if (os_cnt == OS_LAST)
                  begin
                     os_cnt <= '0;
                     if (bit_cnt == 3'd7)
                     begin
                        state    <= TX_STOP;
                        rs232_tx <= 1'b1;
                     end
                     else
                     begin
                        bit_cnt  <= bit_cnt + 3'd1;
                        shreg    <= shreg >> 1;
                        rs232_tx <= shreg[1];
                     end
                  end
                  else
                     os_cnt <= os_cnt + OS_W'(1);
               TX_STOP:
                  if (os_cnt == OS_LAST)
                  begin
                     // frame has left, ready for the next load
                     state        <= TX_IDLE;
                     uif.tx_empty <= 1'b1;
                  end
                  else
                     os_cnt <= os_cnt + OS_W'(1);
               default:
                  state <= TX_IDLE;
            endcase
         end
      end
   end

   a_idle_mark : assert property (@(posedge clk) disable iff (reset) (state == TX_IDLE) |-> rs232_tx);

endmodule

/* src/dl11_baud.sv */
// **************************************
// oversample tick generator, one clk wide pulse
// needs BAUD_DIV of at least 2
// **************************************

`timescale 1ns/1ps

module dl11_baud
   import dl11_pkg::*;
(
   input  logic clk,
   input  logic reset,
   output logic tick
);

   logic [15:0] div_cnt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         tick    <= 1'b0;
      end
      else if (div_cnt == BAUD_DIV - 16'd1)
      begin
         div_cnt <= '0;
         tick    <= 1'b1;
      end
      else
      begin
         div_cnt <= div_cnt + 16'd1;
         tick    <= 1'b0;
      end
   end

   // both UART halves assume isolated single cycle ticks
   a_tick_single : assert property (@(posedge clk) disable iff (reset) tick |=> !tick);

endmodule

/* src/dl11_uart_if.sv */
// **************************************
// level handshakes between the register block and the UART halves
// req is held until ack rises, ack drops once req is low
// **************************************

`timescale 1ns/1ps

interface dl11_uart_if;

   // transmit load
   logic       ld_tx_req;
   logic       ld_tx_ack;
   logic [7:0] tx_data;
   logic       tx_empty;

   // receive unload
   logic       uld_rx_req;
   logic       uld_rx_ack;
   logic [7:0] rx_data;
   logic       rx_empty;

   modport regs (
      output ld_tx_req, tx_data, uld_rx_req,
      input  ld_tx_ack, tx_empty, uld_rx_ack, rx_data, rx_empty
   );

   modport tx (
      input  ld_tx_req, tx_data,
      output ld_tx_ack, tx_empty
   );

   modport rx (
      input  uld_rx_req,
      output uld_rx_ack, rx_data, rx_empty
   );

endinterface

/* src/dl11_pkg.sv */
// **************************************
// shared constants and types for the DL11 console line unit
// baud divider is fixed at build time, no runtime rate select
// one bit lasts BAUD_DIV * OVERSAMPLE clk cycles
// **************************************

package dl11_pkg;

   // I/O page address and data word
   typedef logic [12:0] addr_t;
   typedef logic [15:0] word_t;

   // register offsets inside the I/O page (octal)
   localparam addr_t ADDR_RCSR = 13'o17560;
   localparam addr_t ADDR_RBUF = 13'o17562;
   localparam addr_t ADDR_XCSR = 13'o17564;
   localparam addr_t ADDR_XBUF = 13'o17566;

   // status word bit positions
   localparam int CSR_IE_BIT  = 6;
   localparam int CSR_RDY_BIT = 7;

   // interrupt vectors, receive has priority
   localparam logic [7:0] VEC_RX = 8'o060;
   localparam logic [7:0] VEC_TX = 8'o064;

   // clk cycles per oversample tick
   localparam logic [15:0] BAUD_DIV = 16'd4;

   // oversample ticks per serial bit
   localparam int OVERSAMPLE = 16;
   localparam int OS_W       = $clog2(OVERSAMPLE);
   localparam logic [OS_W-1:0] OS_LAST = OS_W'(OVERSAMPLE - 1);
   localparam logic [OS_W-1:0] OS_HALF = OS_W'(OVERSAMPLE / 2 - 1);

   // host side state machines
   typedef enum logic [1:0] {TTO_IDLE, TTO_WAIT_ACK, TTO_WAIT_ACK_LOW, TTO_WAIT_EMPTY} tto_state_e;
   typedef enum logic [1:0] {TTI_IDLE, TTI_WAIT_ACK, TTI_WAIT_ACK_LOW, TTI_FULL} tti_state_e;

   // serial side state machines
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage
